/* rtl/rv_check_pkg.sv */
package rv_check_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_R     = 7'b0110011,
        OPC_I     = 7'b0010011,
        OPC_IL    = 7'b0000011,
        OPC_JALR  = 7'b1100111,
        OPC_S     = 7'b0100011,
        OPC_B     = 7'b1100011,
        OPC_JAL   = 7'b1101111,
        OPC_LUI   = 7'b0110111,
        OPC_AUIPC = 7'b0010111,
        OPC_FENCE = 7'b0001111,
        OPC_E     = 7'b1110011
    } opcode_t;

    localparam logic [2:0] FN3_XORI = 3'b100;

    // Loads
    localparam logic [2:0] FN3_LB  = 3'b000;
    localparam logic [2:0] FN3_LH  = 3'b001;
    localparam logic [2:0] FN3_LW  = 3'b010;
    localparam logic [2:0] FN3_LBU = 3'b100;
    localparam logic [2:0] FN3_LHU = 3'b101;

    // Stores
    localparam logic [2:0] FN3_SB = 3'b000;
    localparam logic [2:0] FN3_SH = 3'b001;
    localparam logic [2:0] FN3_SW = 3'b010;

    // Branches
    localparam logic [2:0] FN3_BEQ  = 3'b000;
    localparam logic [2:0] FN3_BNE  = 3'b001;
    localparam logic [2:0] FN3_BLT  = 3'b100;
    localparam logic [2:0] FN3_BGE  = 3'b101;
    localparam logic [2:0] FN3_BLTU = 3'b110;
    localparam logic [2:0] FN3_BGEU = 3'b111;

    localparam logic [2:0] FN3_FENCE   = 3'b000;
    localparam logic [2:0] FN3_FENCE_I = 3'b001;

    // Selects SUB and SRA/SRAI
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    typedef struct packed {
        opcode_t                opcode;
        logic [REG_ADDR_W-1:0]  rd;
        logic [2:0]             funct3;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [6:0]             funct7;
        logic [11:0]            imm_i;
        logic [12:0]            imm_b;
        logic [19:0]            uimm;
    } rv_dec_t;

    typedef enum logic [2:0] {
        ERR_NONE       = 3'd0,
        ERR_RESULT     = 3'd1,
        ERR_RD         = 3'd2,
        ERR_WE         = 3'd3,
        ERR_ADDR       = 3'd4,
        ERR_TARGET     = 3'd5,
        ERR_ILLEGAL_WE = 3'd6
    } err_code_t;

    // Status register word offsets
    localparam logic [1:0] REG_RETIRED  = 2'd0;
    localparam logic [1:0] REG_CHECKED  = 2'd1;
    localparam logic [1:0] REG_ERRORS   = 2'd2;
    localparam logic [1:0] REG_LAST_ERR = 2'd3;

endpackage

/* rtl/inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder import rv_check_pkg::*; (
    input  logic [XLEN-1:0] inst_i,
    output rv_dec_t         dec_o,
    output logic            legal_o
);

    logic [9:0] funct_pair;

    // Field extraction
    assign dec_o.opcode = opcode_t'(inst_i[6:0]);
    assign dec_o.rd     = inst_i[11:7];
    assign dec_o.funct3 = inst_i[14:12];
    assign dec_o.rs1    = inst_i[19:15];
    assign dec_o.rs2    = inst_i[24:20];
    assign dec_o.funct7 = inst_i[31:25];
    assign dec_o.imm_i  = inst_i[31:20];
    assign dec_o.imm_b  = {inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign dec_o.uimm   = inst_i[31:12];

    assign funct_pair = {dec_o.funct7, dec_o.funct3};

    always_comb begin
        legal_o = 1'b0;
        case (dec_o.opcode)
            OPC_LUI, OPC_AUIPC: legal_o = 1'b1;
            // J offset bit 1 sits in inst[21]
            OPC_JAL:  legal_o = (inst_i[21] == 1'b0);
            OPC_JALR: legal_o = (dec_o.funct3 == 3'b000);
            OPC_B: begin
                legal_o = (dec_o.funct3 inside {FN3_BEQ, FN3_BNE, FN3_BLT,
                                                FN3_BGE, FN3_BLTU, FN3_BGEU})
                          && (dec_o.imm_b[1] == 1'b0);
            end
            OPC_IL: begin
                legal_o = dec_o.funct3 inside {FN3_LB, FN3_LH, FN3_LW, FN3_LBU, FN3_LHU};
            end
            OPC_S: legal_o = dec_o.funct3 inside {FN3_SB, FN3_SH, FN3_SW};
            OPC_I: begin
                // Only the shifts constrain funct7
                if (dec_o.funct3 == 3'b001) begin
                    legal_o = (dec_o.funct7 == 7'b0);
                end else if (dec_o.funct3 == 3'b101) begin
                    legal_o = (dec_o.funct7 == 7'b0) || (dec_o.funct7 == FUNCT7_ALT);
                end else begin
                    legal_o = 1'b1;
                end
            end
            OPC_R: begin
                legal_o = (dec_o.funct7 == 7'b0)
                          || (funct_pair == {FUNCT7_ALT, 3'b000})
                          || (funct_pair == {FUNCT7_ALT, 3'b101});
            end
            OPC_FENCE: begin
                if (dec_o.funct3 == FN3_FENCE) begin
                    legal_o = (inst_i[31:28] == 4'b0) && (dec_o.rs1 == '0)
                              && (dec_o.rd == '0);
                end else if (dec_o.funct3 == FN3_FENCE_I) begin
                    legal_o = (dec_o.imm_i == '0) && (dec_o.rs1 == '0) && (dec_o.rd == '0);
                end
            end
            // ECALL and EBREAK differ only in bit 20
            OPC_E: legal_o = (inst_i[31:21] == '0) && (inst_i[19:7] == '0);
            default: legal_o = 1'b0;
        endcase
    end

endmodule

/* rtl/golden_alu.sv */
`timescale 1ns/1ns

module golden_alu import rv_check_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid_i,
    input  rv_dec_t               dec_i,
    input  logic                  legal_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       rs1_val_i,
    input  logic [XLEN-1:0]       mem_addr_i,
    input  logic [XLEN-1:0]       mem_rdata_i,
    input  logic [XLEN-1:0]       wb_data_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic                  wb_we_i,
    output logic                  checked_o,
    output logic                  err_o,
    output err_code_t             err_code_o,
    output logic [XLEN-1:0]       err_pc_o,
    output logic                  illegal_o
);

    logic            is_xori;
    logic            is_auipc;
    logic            is_lb;
    logic            is_target;
    logic [XLEN-1:0] imm_i_sx;
    logic [XLEN-1:0] lb_addr;
    logic [XLEN-1:0] lb_word;
    logic [XLEN-1:0] gold_res;
    err_code_t       code_d;

    assign is_xori   = legal_i && (dec_i.opcode == OPC_I) && (dec_i.funct3 == FN3_XORI);
    assign is_auipc  = legal_i && (dec_i.opcode == OPC_AUIPC);
    assign is_lb     = legal_i && (dec_i.opcode == OPC_IL) && (dec_i.funct3 == FN3_LB);
    assign is_target = is_xori || is_auipc || is_lb;

    assign imm_i_sx = {{(XLEN-12){dec_i.imm_i[11]}}, dec_i.imm_i};
    assign lb_addr  = rs1_val_i + imm_i_sx;
    // Byte lane picked by the golden address
    assign lb_word  = mem_rdata_i >> {lb_addr[1:0], 3'b000};

    always_comb begin
        if (is_xori) begin
            gold_res = rs1_val_i ^ imm_i_sx;
        end else if (is_auipc) begin
            gold_res = pc_i + {dec_i.uimm, 12'b0};
        end else begin
            gold_res = {{(XLEN-8){lb_word[7]}}, lb_word[7:0]};
        end
    end

    // First failing check decides the code
    always_comb begin
        code_d = ERR_NONE;
        if (!legal_i) begin
            if (wb_we_i) begin
                code_d = ERR_ILLEGAL_WE;
            end
        end else if (is_target) begin
            if (is_lb && (mem_addr_i != lb_addr)) begin
                code_d = ERR_ADDR;
            end else if (wb_data_i != gold_res) begin
                code_d = ERR_RESULT;
            end else if (wb_rd_i != dec_i.rd) begin
                code_d = ERR_RD;
            end else if (wb_we_i != (dec_i.rd != '0)) begin
                code_d = ERR_WE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            checked_o <= 1'b0;
            err_o     <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            checked_o <= valid_i && is_target;
            err_o     <= valid_i && (code_d != ERR_NONE);
            illegal_o <= valid_i && !legal_i;
        end
    end

    always_ff @(posedge clk) begin
        err_code_o <= code_d;
        err_pc_o   <= pc_i;
    end

    a_err_has_code: assert property (@(posedge clk) disable iff (rst)
        err_o |-> (err_code_o != ERR_NONE));

endmodule

/* rtl/branch_tracker.sv */
`timescale 1ns/1ns

module branch_tracker import rv_check_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            valid_i,
    input  rv_dec_t         dec_i,
    input  logic            legal_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_val_i,
    input  logic [XLEN-1:0] rs2_val_i,
    output logic            err_o,
    output err_code_t       err_code_o,
    output logic [XLEN-1:0] err_pc_o,
    output logic            checked_o
);

    typedef enum logic {
        IDLE,
        PENDING
    } state_t;

    state_t          state_q;
    logic            is_blt;
    logic            taken;
    logic [XLEN-1:0] target_d;
    logic [XLEN-1:0] target_q;
    logic [XLEN-1:0] blt_pc_q;
    logic            check_now;

    assign is_blt = valid_i && legal_i && (dec_i.opcode == OPC_B) && (dec_i.funct3 == FN3_BLT);
    assign taken  = $signed(rs1_val_i) < $signed(rs2_val_i);
    assign target_d = taken ? pc_i + {{(XLEN-13){dec_i.imm_b[12]}}, dec_i.imm_b}
                            : pc_i + XLEN'(4);

    // Next retired beat after a BLT
    assign check_now = (state_q == PENDING) && valid_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else if (is_blt) begin
            // Back-to-back BLT keeps the tracker armed
            state_q <= PENDING;
        end else if (check_now) begin
            state_q <= IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            err_o     <= 1'b0;
            checked_o <= 1'b0;
        end else begin
            err_o     <= check_now && (pc_i != target_q);
            checked_o <= check_now;
        end
    end

    always_ff @(posedge clk) begin
        if (is_blt) begin
            target_q <= target_d;
            blt_pc_q <= pc_i;
        end
        err_code_o <= ERR_TARGET;
        err_pc_o   <= blt_pc_q;
    end

    a_check_after_pending: assert property (@(posedge clk) disable iff (rst)
        checked_o |-> $past(state_q == PENDING));

endmodule

/* rtl/check_counter.sv */
`timescale 1ns/1ns

module check_counter #(
    parameter int CNT_W = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             clear_i,
    input  logic             retired_i,
    input  logic             checked_i,
    input  logic             error_i,
    output logic [CNT_W-1:0] retired_cnt_o,
    output logic [CNT_W-1:0] checked_cnt_o,
    output logic [CNT_W-1:0] error_cnt_o
);

    localparam int NUM_CNT = 3;

    logic [NUM_CNT-1:0] inc;
    logic [CNT_W-1:0]   cnt_q [NUM_CNT];

    // Index 0 retired, 1 checked, 2 errors
    assign inc = {error_i, checked_i, retired_i};

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CNT; i++) begin
            if (rst) begin
                cnt_q[i] <= '0;
            end else if (clear_i) begin
                cnt_q[i] <= '0;
            end else if (inc[i] && (cnt_q[i] != {CNT_W{1'b1}})) begin
                // Saturates at all ones
                cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

    assign retired_cnt_o = cnt_q[0];
    assign checked_cnt_o = cnt_q[1];
    assign error_cnt_o   = cnt_q[2];

    // Every error strobe lines up with a retired strobe at the top level
    a_errors_le_retired: assert property (@(posedge clk) disable iff (rst)
        error_cnt_o <= retired_cnt_o);

endmodule

/* rtl/wb_status_regs.sv */
`timescale 1ns/1ns

module wb_status_regs import rv_check_pkg::*; #(
    parameter int CNT_W = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  logic [1:0]       wb_adr_i,
    input  logic [XLEN-1:0]  wb_dat_i,
    input  logic [CNT_W-1:0] retired_cnt_i,
    input  logic [CNT_W-1:0] checked_cnt_i,
    input  logic [CNT_W-1:0] error_cnt_i,
    input  logic             err_i,
    input  err_code_t        err_code_i,
    input  logic [XLEN-1:0]  err_pc_i,
    output logic [XLEN-1:0]  wb_dat_o,
    output logic             wb_ack_o,
    output logic             clear_o
);

    logic            req;
    logic [XLEN-1:0] last_err_q;
    logic [XLEN-1:0] rd_data;

    // New request only when no ack is pending
    assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

    always_comb begin
        case (wb_adr_i)
            REG_RETIRED: rd_data = XLEN'(retired_cnt_i);
            REG_CHECKED: rd_data = XLEN'(checked_cnt_i);
            REG_ERRORS:  rd_data = XLEN'(error_cnt_i);
            default:     rd_data = last_err_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack_o   <= 1'b0;
            clear_o    <= 1'b0;
            last_err_q <= '0;
        end else begin
            wb_ack_o <= req;
            // Any write to offset 0 clears the counters
            clear_o  <= req && wb_we_i && (wb_adr_i == REG_RETIRED);
            if (clear_o) begin
                last_err_q <= '0;
            end else if (err_i) begin
                // PC bits 31:3 above the 3-bit error code
                last_err_q <= {err_pc_i[XLEN-1:3], err_code_i};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_o <= rd_data;
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_ack_o |=> !wb_ack_o);

endmodule

/* rtl/rv_retire_check.sv */
`timescale 1ns/1ns

module rv_retire_check import rv_check_pkg::*; #(
    parameter int CNT_W = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    // Retire port
    input  logic                  ret_valid_i,
    input  logic [XLEN-1:0]       ret_inst_i,
    input  logic [XLEN-1:0]       ret_pc_i,
    input  logic [XLEN-1:0]       ret_rs1_val_i,
    input  logic [XLEN-1:0]       ret_rs2_val_i,
    input  logic [XLEN-1:0]       ret_mem_addr_i,
    input  logic [XLEN-1:0]       ret_mem_rdata_i,
    input  logic [XLEN-1:0]       ret_wb_data_i,
    input  logic [REG_ADDR_W-1:0] ret_wb_rd_i,
    input  logic                  ret_wb_we_i,
    // Wishbone status port
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [1:0]            wb_adr_i,
    input  logic [XLEN-1:0]       wb_dat_i,
    output logic [XLEN-1:0]       wb_dat_o,
    output logic                  wb_ack_o,
    output logic                  chk_err_o,
    output logic                  chk_illegal_o
);

    rv_dec_t          dec;
    logic             legal;
    logic             alu_checked;
    logic             alu_err;
    err_code_t        alu_code;
    logic [XLEN-1:0]  alu_pc;
    logic             br_checked;
    logic             br_err;
    err_code_t        br_code;
    logic [XLEN-1:0]  br_pc;
    err_code_t        err_code;
    logic [XLEN-1:0]  err_pc;
    logic             retired_q;
    logic             clear;
    logic [CNT_W-1:0] retired_cnt;
    logic [CNT_W-1:0] checked_cnt;
    logic [CNT_W-1:0] error_cnt;

    inst_decoder u_dec (
        .inst_i  (ret_inst_i),
        .dec_o   (dec),
        .legal_o (legal)
    );

    golden_alu u_alu (
        .clk(clk), .rst(rst), .valid_i(ret_valid_i), .dec_i(dec), .legal_i(legal),
        .pc_i(ret_pc_i), .rs1_val_i(ret_rs1_val_i), .mem_addr_i(ret_mem_addr_i),
        .mem_rdata_i(ret_mem_rdata_i), .wb_data_i(ret_wb_data_i), .wb_rd_i(ret_wb_rd_i),
        .wb_we_i(ret_wb_we_i), .checked_o(alu_checked), .err_o(alu_err),
        .err_code_o(alu_code), .err_pc_o(alu_pc), .illegal_o(chk_illegal_o)
    );

    branch_tracker u_br (
        .clk(clk), .rst(rst), .valid_i(ret_valid_i), .dec_i(dec), .legal_i(legal),
        .pc_i(ret_pc_i), .rs1_val_i(ret_rs1_val_i), .rs2_val_i(ret_rs2_val_i),
        .err_o(br_err), .err_code_o(br_code), .err_pc_o(br_pc), .checked_o(br_checked)
    );

    // Tracker reports an older beat, so it wins
    assign chk_err_o = alu_err || br_err;
    assign err_code  = br_err ? br_code : alu_code;
    assign err_pc    = br_err ? br_pc : alu_pc;

    // Align retire strobe with the registered check strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            retired_q <= 1'b0;
        end else begin
            retired_q <= ret_valid_i;
        end
    end

    check_counter #(.CNT_W(CNT_W)) u_cnt (
        .clk(clk), .rst(rst), .clear_i(clear), .retired_i(retired_q),
        .checked_i(alu_checked || br_checked), .error_i(chk_err_o),
        .retired_cnt_o(retired_cnt), .checked_cnt_o(checked_cnt), .error_cnt_o(error_cnt)
    );

    wb_status_regs #(.CNT_W(CNT_W)) u_wb (
        .clk(clk), .rst(rst), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .retired_cnt_i(retired_cnt),
        .checked_cnt_i(checked_cnt), .error_cnt_i(error_cnt), .err_i(chk_err_o),
        .err_code_i(err_code), .err_pc_i(err_pc), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .clear_o(clear)
    );

endmodule

/* tests/clk_gen.sv */
`timescale 1ns/1ns

module clk_gen #(
    parameter int PERIOD = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

/* tests/tb_rv_retire_check.sv */
`timescale 1ns/1ns

module tb_rv_retire_check;

    localparam int MAX_BEATS = 64;

    logic        clk;
    logic        rst;
    logic        ret_valid;
    logic [31:0] ret_inst, ret_pc, ret_rs1, ret_rs2, ret_maddr, ret_mrdata, ret_wdata;
    logic [4:0]  ret_rd;
    logic        ret_we;
    logic        wb_cyc, wb_stb, wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        chk_err, chk_illegal;

    // Golden columns
    logic [31:0] g_inst [MAX_BEATS];
    logic [31:0] g_pc [MAX_BEATS];
    logic [31:0] g_rs1 [MAX_BEATS];
    logic [31:0] g_rs2 [MAX_BEATS];
    logic [31:0] g_maddr [MAX_BEATS];
    logic [31:0] g_mrdata [MAX_BEATS];
    logic [31:0] g_wdata [MAX_BEATS];
    logic [31:0] g_rd [MAX_BEATS];
    logic [31:0] g_we [MAX_BEATS];
    logic [31:0] g_err [MAX_BEATS];
    logic [31:0] g_ill [MAX_BEATS];
    logic [31:0] g_chk [MAX_BEATS];
    logic [31:0] g_code [MAX_BEATS];

    int     num_beats;
    int     tests_run;
    int     tests_failed;
    integer seed;
    logic   loaded;

    // Expectations travel one cycle behind the driven beat
    logic exp_v, exp_err, exp_ill;
    int   exp_idx;
    logic st_v, st_err, st_ill;
    int   st_idx;

    clk_gen #(.PERIOD(20)) u_clk (.clk_o(clk));

    rv_retire_check #(.CNT_W(32)) dut0 (
        .clk(clk), .rst(rst), .ret_valid_i(ret_valid), .ret_inst_i(ret_inst),
        .ret_pc_i(ret_pc), .ret_rs1_val_i(ret_rs1), .ret_rs2_val_i(ret_rs2),
        .ret_mem_addr_i(ret_maddr), .ret_mem_rdata_i(ret_mrdata), .ret_wb_data_i(ret_wdata),
        .ret_wb_rd_i(ret_rd), .ret_wb_we_i(ret_we), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
        .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r),
        .wb_ack_o(wb_ack), .chk_err_o(chk_err), .chk_illegal_o(chk_illegal)
    );

    task automatic load_golden();
        int    fd;
        int    n;
        string line;
        fd = $fopen("tests/golden_retire.txt", "r");
        num_beats = 0;
        if (fd == 0) begin
            $display("Cannot open tests/golden_retire.txt");
            return;
        end
        while (!$feof(fd) && num_beats < MAX_BEATS) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                        g_inst[num_beats], g_pc[num_beats], g_rs1[num_beats],
                        g_rs2[num_beats], g_maddr[num_beats], g_mrdata[num_beats],
                        g_wdata[num_beats], g_rd[num_beats], g_we[num_beats],
                        g_err[num_beats], g_ill[num_beats], g_chk[num_beats],
                        g_code[num_beats]);
            if (n == 13) begin
                num_beats++;
            end
        end
        $fclose(fd);
    endtask

    task automatic wb_access(input logic write, input logic [1:0] adr, output logic [31:0] data);
        int wait_cnt;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= write;
        wb_adr   <= adr;
        wb_dat_w <= 32'h0000_0001;
        wait_cnt = 0;
        @(negedge clk);
        while (!wb_ack && wait_cnt < 16) begin
            @(negedge clk);
            wait_cnt++;
        end
        data = wb_dat_r;
        if (!wb_ack) begin
            $display("Wishbone access to offset %0d got no ack", adr);
            tests_failed++;
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic check_reg(input logic [1:0] adr, input logic [31:0] expected,
                             input string name);
        logic [31:0] data;
        wb_access(1'b0, adr, data);
        tests_run++;
        if (data !== expected) begin
            $display("MISMATCH at %0t: %s read %h, expected %h", $time, name, data, expected);
            tests_failed++;
        end else begin
            $display("Test %s: ok (%h)", name, data);
        end
    endtask

    always @(posedge clk) begin
        st_v   <= exp_v;
        st_err <= exp_err;
        st_ill <= exp_ill;
        st_idx <= exp_idx;
    end

    // Flags for the beat driven one cycle earlier
    always @(negedge clk) begin
        if (!rst) begin
            if (chk_err !== st_err || chk_illegal !== st_ill) begin
                $display("MISMATCH at %0t: beat %0d err=%b ill=%b, expected err=%b ill=%b",
                         $time, st_idx, chk_err, chk_illegal, st_err, st_ill);
                tests_failed++;
            end else if (st_v) begin
                $display("Test beat %0d: ok", st_idx);
            end
            if (st_v) begin
                tests_run++;
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (num_beats * 4 + 200) @(posedge clk);
        $display("Watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int          gap;
        int          sum_chk;
        int          sum_err;
        logic [31:0] last_err;
        logic [31:0] dummy;
        seed = 32'h796ef8d7;
        rst = 1'b1;
        loaded = 1'b0;
        ret_valid = 1'b0;
        {ret_inst, ret_pc, ret_rs1, ret_rs2, ret_maddr, ret_mrdata, ret_wdata} = '0;
        ret_rd = '0;
        ret_we = 1'b0;
        {wb_cyc, wb_stb, wb_we} = 3'b000;
        wb_adr = '0;
        wb_dat_w = '0;
        {exp_v, exp_err, exp_ill} = 3'b000;
        exp_idx = 0;
        tests_run = 0;
        tests_failed = 0;
        sum_chk = 0;
        sum_err = 0;
        last_err = '0;
        load_golden();
        loaded = 1'b1;
        if (num_beats == 0) begin
            tests_failed++;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < num_beats; i++) begin
            gap = $random(seed) & 3;
            repeat (gap) begin
                @(posedge clk);
                ret_valid <= 1'b0;
                exp_v     <= 1'b0;
                exp_err   <= 1'b0;
                exp_ill   <= 1'b0;
            end
            @(posedge clk);
            ret_valid  <= 1'b1;
            ret_inst   <= g_inst[i];
            ret_pc     <= g_pc[i];
            ret_rs1    <= g_rs1[i];
            ret_rs2    <= g_rs2[i];
            ret_maddr  <= g_maddr[i];
            ret_mrdata <= g_mrdata[i];
            ret_wdata  <= g_wdata[i];
            ret_rd     <= g_rd[i][4:0];
            ret_we     <= g_we[i][0];
            exp_v      <= 1'b1;
            exp_err    <= g_err[i][0];
            exp_ill    <= g_ill[i][0];
            exp_idx    <= i;
            sum_chk += g_chk[i];
            sum_err += g_err[i];
            // Target errors report the PC of the BLT before
            if (g_err[i][0]) begin
                if (g_code[i][2:0] == 3'd5 && i > 0) begin
                    last_err = {g_pc[i-1][31:3], g_code[i][2:0]};
                end else begin
                    last_err = {g_pc[i][31:3], g_code[i][2:0]};
                end
            end
        end
        @(posedge clk);
        ret_valid <= 1'b0;
        exp_v     <= 1'b0;
        exp_err   <= 1'b0;
        exp_ill   <= 1'b0;
        // Counters settle two cycles after the last beat
        repeat (4) @(posedge clk);

        check_reg(2'd0, num_beats, "retired_count");
        check_reg(2'd1, sum_chk, "checked_count");
        check_reg(2'd2, sum_err, "error_count");
        check_reg(2'd3, last_err, "last_error");

        wb_access(1'b1, 2'd0, dummy);
        repeat (2) @(posedge clk);
        check_reg(2'd0, 32'd0, "retired_after_clear");
        check_reg(2'd1, 32'd0, "checked_after_clear");
        check_reg(2'd2, 32'd0, "errors_after_clear");
        check_reg(2'd3, 32'd0, "last_error_after_clear");

        $display("Tests run: %0d, failures: %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* rv_retire_check.f */
rtl/rv_check_pkg.sv
rtl/inst_decoder.sv
rtl/golden_alu.sv
rtl/branch_tracker.sv
rtl/check_counter.sv
rtl/wb_status_regs.sv
rtl/rv_retire_check.sv
tests/clk_gen.sv
tests/tb_rv_retire_check.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the retire checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f rv_retire_check.f \
    --top-module tb_rv_retire_check \
    --Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* tests/golden_retire.txt */
# inst pc rs1_val rs2_val mem_addr mem_rdata wb_data wb_rd wb_we | exp_err exp_ill exp_chk exp_code
# all columns hex, one retire beat per line
0F034293 00000100 12345678 00000000 00000000 00000000 12345688 05 1 0 0 1 0
0F034293 00000104 12345678 00000000 00000000 00000000 12345689 05 1 1 0 1 1
0F034293 00000108 12345678 00000000 00000000 00000000 12345688 06 1 1 0 1 2
0F034293 0000010C 12345678 00000000 00000000 00000000 12345688 05 0 1 0 1 3
FFF34293 00000110 12345678 00000000 00000000 00000000 EDCBA987 05 1 0 0 1 0
0F034013 00000114 12345678 00000000 00000000 00000000 12345688 00 0 0 0 1 0
12345397 00001000 00000000 00000000 00000000 00000000 12346000 07 1 0 0 1 0
12345397 00001004 00000000 00000000 00000000 00000000 12345000 07 1 1 0 1 1
00448403 00000120 00002000 00000000 00002004 80FF7F11 00000011 08 1 0 0 1 0
00448403 00000124 00002001 00000000 00002005 80FF7F11 0000007F 08 1 0 0 1 0
00448403 00000128 00002002 00000000 00002006 80FF7F11 FFFFFFFF 08 1 0 0 1 0
00448403 0000012C 00002003 00000000 00002007 80FF7F11 FFFFFF80 08 1 0 0 1 0
00448403 00000130 00002000 00000000 00002008 80FF7F11 00000011 08 1 1 0 1 4
00448403 00000134 00002003 00000000 00002007 80FF7F11 00000080 08 1 1 0 1 1
0020C863 00000200 FFFFFFFF 00000001 00000000 00000000 00000000 00 0 0 0 0 0
0F034293 00000210 12345678 00000000 00000000 00000000 12345688 05 1 0 0 1 0
0020C863 00000300 00000005 00000001 00000000 00000000 00000000 00 0 0 0 0 0
00000033 00000304 00000000 00000000 00000000 00000000 00000000 00 0 0 0 1 0
0020C863 00000400 FFFFFFFF 00000001 00000000 00000000 00000000 00 0 0 0 0 0
00000033 00000404 00000000 00000000 00000000 00000000 00000000 00 0 1 0 1 5
0020C863 00000500 00000005 00000001 00000000 00000000 00000000 00 0 0 0 0 0
0020C863 00000504 FFFFFFFF 00000001 00000000 00000000 00000000 00 0 0 0 1 0
00000033 00000514 00000000 00000000 00000000 00000000 00000000 00 0 0 0 1 0
00000000 00000600 00000000 00000000 00000000 00000000 00000000 00 0 0 1 0 0
00001067 00000604 00000000 00000000 00000000 00000000 00000000 00 0 0 1 0 0
FFFFFFFF 00000608 00000000 00000000 00000000 00000000 00000000 03 1 1 1 0 6
00000033 0000060C 00000000 00000000 00000000 00000000 00000000 00 0 0 0 0 0
